/* mesh_router.f */
mesh_pkg.sv
mesh_req_if.sv
mesh_input_unit.sv
mesh_switch_allocator.sv
mesh_switch.sv
mesh_router.sv
mesh_router_props.sv
mesh_router_tb.sv

/* Bender.yml */
package:
  name: mesh_router

sources:
  - mesh_pkg.sv
  - mesh_req_if.sv
  - mesh_input_unit.sv
  - mesh_switch_allocator.sv
  - mesh_switch.sv
  - mesh_router.sv
  - target: test
    files:
      - mesh_router_props.sv
      - mesh_router_tb.sv

/* mesh_router_tb.sv */
// ----------------------------------------------------------
// Mesh router testbench
// Directed and random single-flit traffic into a router at
// position 2,2, checked by a per input and output scoreboard
// ----------------------------------------------------------

module mesh_router_tb import mesh_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // Router position in the mesh
  localparam int my_x  = 2;
  localparam int my_y  = 2;
  // Payload holds source port and a sequence number
  localparam int seq_w = payload_w - 3;

  logic               clk = 1'b0;
  logic               rst_n;
  logic [n_ports-1:0] in_valid;
  logic [flit_w-1:0]  in_flit   [0:n_ports-1];
  logic [n_ports-1:0] in_full;
  logic [n_ports-1:0] out_valid;
  logic [flit_w-1:0]  out_flit  [0:n_ports-1];

  // Expected flits, indexed by input then output
  logic [flit_w-1:0]  exp_q [n_ports][n_ports][$];
  int                 errors   = 0;
  int                 timeouts = 0;
  int                 cycle    = 0;
  int                 seed     = 37589;
  logic [seq_w-1:0]   seq      = '0;
  int                 last_out_cycle [n_ports];
  logic [n_ports-1:0] full_seen;
  // Arrival log of the west output
  int                 west_src [$];
  int                 west_cyc [$];

  mesh_router #(
    .x_pos (my_x),
    .y_pos (my_y)
  ) mesh_router_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_flit   (in_flit),
    .in_full   (in_full),
    .out_valid (out_valid),
    .out_flit  (out_flit)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // ----------------------------------------------------------
  // Reference rules and helpers
  // ----------------------------------------------------------
  // XY routing, X first, larger X east, larger Y north
  function automatic int xy_port(input logic [flit_w-1:0] f);
    int dx;
    int dy;
    dx = f[dest_x_lsb +: coord_w];
    dy = f[dest_y_lsb +: coord_w];
    if (dx != my_x) return (dx > my_x) ? port_east : port_west;
    if (dy != my_y) return (dy > my_y) ? port_north : port_south;
    return port_local;
  endfunction

  // Unique flit, tagged with its source port
  function automatic logic [flit_w-1:0] make_flit(input int src, input int dx, input int dy);
    logic [flit_w-1:0] f;
    f = '0;
    f[dest_x_lsb +: coord_w]    = coord_w'(dx);
    f[dest_y_lsb +: coord_w]    = coord_w'(dy);
    f[payload_lsb +: payload_w] = {3'(src), seq};
    seq = seq + 1'b1;
    return f;
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int i = 0; i < n_ports; i++) begin
      for (int o = 0; o < n_ports; o++) begin
        n += exp_q[i][o].size();
      end
    end
    return n;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // One cycle of strobes, full inputs are skipped
  task automatic strobe(input logic [n_ports-1:0] want, output logic [n_ports-1:0] sent);
    for (int p = 0; p < n_ports; p++) begin
      in_valid[p] = want[p] & ~in_full[p];
      if (in_valid[p]) begin
        exp_q[p][xy_port(in_flit[p])].push_back(in_flit[p]);
      end
    end
    sent = in_valid;
    step();
    in_valid = '0;
  endtask

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while (pending() != 0 && n < limit) begin
      step();
      n++;
    end
    if (pending() != 0) begin
      timeouts++;
      $display("Timeout: %0d expected flits never left the router", pending());
    end
  endtask

  task automatic check_idle();
    assert (out_valid == '0) else begin
      errors++;
      $display("FAILED %0t out_valid got %b expected %b", $time, out_valid, 5'b0);
    end
    assert (in_full == '0) else begin
      errors++;
      $display("FAILED %0t in_full got %b expected %b", $time, in_full, 5'b0);
    end
  endtask

  // ----------------------------------------------------------
  // Output monitor and scoreboard
  // ----------------------------------------------------------
  always @(negedge clk) begin : monitor
    int src;
    logic [flit_w-1:0] want_flit;
    if (rst_n) begin
      full_seen = full_seen | in_full;
      for (int o = 0; o < n_ports; o++) begin
        if (out_valid[o]) begin
          src = out_flit[o][payload_lsb + seq_w +: 3];
          last_out_cycle[o] = cycle;
          if (src >= n_ports || exp_q[src][o].size() == 0) begin
            errors++;
            $display("Unexpected flit %h on output %0d at %0t", out_flit[o], o, $time);
          end else begin
            want_flit = exp_q[src][o].pop_front();
            assert (out_flit[o] == want_flit) else begin
              errors++;
              $display("FAILED %0t out_flit[%0d] got %h expected %h",
                       $time, o, out_flit[o], want_flit);
            end
            if (o == port_west) begin
              west_src.push_back(src);
              west_cyc.push_back(cycle);
            end
          end
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Directed and random scenarios
  // ----------------------------------------------------------
  // Single flit, fixed two-cycle latency
  task automatic route_one(input int src, input int dx, input int dy);
    int port;
    int t0;
    int n;
    logic [n_ports-1:0] sent;
    n = 0;
    in_flit[src] = make_flit(src, dx, dy);
    port = xy_port(in_flit[src]);
    strobe(n_ports'(1 << src), sent);
    t0 = cycle;
    while (exp_q[src][port].size() != 0 && n < 20) begin
      step();
      n++;
    end
    if (exp_q[src][port].size() != 0) begin
      timeouts++;
      $display("Timeout waiting for flit from input %0d on output %0d", src, port);
    end else begin
      assert (last_out_cycle[port] - t0 == 2) else begin
        errors++;
        $display("FAILED %0t latency of out_valid[%0d] got %0d expected %0d",
                 $time, port, last_out_cycle[port] - t0, 2);
      end
    end
  endtask

  // North and south race for west
  task automatic contend(input int reps);
    int prev_last;
    int n;
    logic [n_ports-1:0] want;
    logic [n_ports-1:0] sent;
    prev_last = -1;
    want = '0;
    want[port_north] = 1'b1;
    want[port_south] = 1'b1;
    for (int r = 0; r < reps; r++) begin
      west_src.delete();
      west_cyc.delete();
      in_flit[port_north] = make_flit(port_north, 0, my_y);
      in_flit[port_south] = make_flit(port_south, 0, my_y);
      strobe(want, sent);
      n = 0;
      while (west_src.size() < 2 && n < 20) begin
        step();
        n++;
      end
      if (west_src.size() < 2) begin
        timeouts++;
        $display("Timeout waiting for both contending flits on the west output");
      end else begin
        assert (west_cyc[1] - west_cyc[0] == 1) else begin
          errors++;
          $display("FAILED %0t west out_valid gap got %0d expected %0d",
                   $time, west_cyc[1] - west_cyc[0], 1);
        end
        // Round robin resumes after the last winner
        assert (west_src[0] != prev_last) else begin
          errors++;
          $display("FAILED %0t west winner got %0d expected %0d",
                   $time, west_src[0], west_src[1]);
        end
        prev_last = west_src[1];
      end
    end
  endtask

  // Many sources into one output, to fill FIFOs
  task automatic flood(input logic [n_ports-1:0] srcs, input int total, input bit rand_dest);
    int remaining;
    int n;
    logic [n_ports-1:0] want;
    logic [n_ports-1:0] sent;
    remaining = total;
    n = 0;
    while (remaining > 0 && n < 20 * total) begin
      want = '0;
      for (int p = 0; p < n_ports; p++) begin
        if (srcs[p] && $countones(want) < remaining && ($random(seed) % 2 != 0 || !rand_dest)) begin
          want[p] = 1'b1;
          if (rand_dest) begin
            in_flit[p] = make_flit(p, $unsigned($random(seed)) % 5, $unsigned($random(seed)) % 5);
          end else begin
            in_flit[p] = make_flit(p, 4, my_y);
          end
        end
      end
      strobe(want, sent);
      remaining -= $countones(sent);
      n++;
    end
    if (remaining > 0) begin
      timeouts++;
      $display("Timeout: %0d flits could not be sent into the router", remaining);
    end
  endtask

  initial begin
    logic [n_ports-1:0] fill_mask;
    rst_n    = 1'b0;
    in_valid = '0;
    for (int p = 0; p < n_ports; p++) begin
      in_flit[p] = '0;
      last_out_cycle[p] = 0;
    end
    full_seen = '0;

    // Reset held for ten edges
    repeat (10) begin
      step();
      check_idle();
    end
    rst_n = 1'b1;
    step();
    check_idle();

    route_one(port_local, 3, 2);
    route_one(port_local, 1, 2);
    route_one(port_local, 2, 3);
    route_one(port_local, 2, 1);
    route_one(port_north, 2, 2);
    contend(3);

    // Every port except east floods east
    fill_mask = '1;
    fill_mask[port_east] = 1'b0;
    full_seen = '0;
    flood(fill_mask, 48, 1'b0);
    wait_drained(200);
    assert ((full_seen & fill_mask) == fill_mask) else begin
      errors++;
      $display("FAILED %0t in_full seen got %b expected %b", $time, full_seen, fill_mask);
    end

    flood('1, 300, 1'b1);
    wait_drained(2000);

    $display("Errors: %0d check failures, %0d timeouts, %0d property failures",
             errors, timeouts, mesh_router_i.props_i.fail_count);
    if (errors == 0 && timeouts == 0 && mesh_router_i.props_i.fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* mesh_router_props.sv */
// ----------------------------------------------------------
// Mesh router properties
// Bound checks on reset, crossbar selects, grants and strobes
// ----------------------------------------------------------

module mesh_router_props import mesh_pkg::*; (
  input logic               clk,
  input logic               rst_n,
  input logic [n_ports-1:0] in_valid,
  input logic [n_ports-1:0] in_full,
  input logic [n_ports-1:0] out_valid,
  input logic [n_ports-1:0] sel [0:n_ports-1],
  input logic [n_ports-1:0] req_valid,
  input logic [n_ports-1:0] grant
);

  timeunit 1ns;
  timeprecision 1ps;

  // Failed property count
  int fail_count = 0;

  // Synchronous reset clears outputs by the next edge
  reset_clears_outputs: assert property (
    @(posedge clk) !rst_n |=> (out_valid == '0 && in_full == '0)
  ) else begin
    fail_count++;
    $error("out_valid or in_full not low after a reset edge");
  end

  // Each output picks at most one input
  for (genvar o = 0; o < n_ports; o++) begin : g_sel
    sel_onehot: assert property (
      @(posedge clk) disable iff (!rst_n) $onehot0(sel[o])
    ) else begin
      fail_count++;
      $error("crossbar select of output %0d is not one-hot", o);
    end
  end

  // Grant only pops a FIFO with a visible head
  grant_needs_valid: assert property (
    @(posedge clk) disable iff (!rst_n) (grant & ~req_valid) == '0
  ) else begin
    fail_count++;
    $error("grant given to an input without a head flit");
  end

  // Sender honors the full level
  no_strobe_when_full: assert property (
    @(posedge clk) disable iff (!rst_n) (in_valid & in_full) == '0
  ) else begin
    fail_count++;
    $error("in_valid strobed while in_full is high");
  end

endmodule

bind mesh_router mesh_router_props props_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .in_full   (in_full),
  .out_valid (out_valid),
  .sel       (sel),
  .req_valid (u_alloc.valid_vec),
  .grant     (u_alloc.grant_vec)
);

/* mesh_router.sv */
// ----------------------------------------------------------
// Mesh router top level
// Five input units, switch allocator, crossbar and
// registered outputs for one node of a 2D mesh
// ----------------------------------------------------------

module mesh_router import mesh_pkg::*; #(
  parameter int x_pos = 0,
  parameter int y_pos = 0
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [n_ports-1:0] in_valid,
  input  logic [flit_w-1:0]  in_flit   [0:n_ports-1],
  output logic [n_ports-1:0] in_full,
  output logic [n_ports-1:0] out_valid,
  output logic [flit_w-1:0]  out_flit  [0:n_ports-1]
);

  // One request bus per input port
  mesh_req_if req_bus [0:n_ports-1] ();

  logic [flit_w-1:0]  head_flit [0:n_ports-1];
  logic [flit_w-1:0]  xbar_flit [0:n_ports-1];
  logic [n_ports-1:0] sel       [0:n_ports-1];

  // ----------------------------------------------------------
  // Input units
  // ----------------------------------------------------------
  for (genvar p = 0; p < n_ports; p++) begin : g_input
    mesh_input_unit #(
      .x_pos (x_pos),
      .y_pos (y_pos)
    ) u_input (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (in_valid[p]),
      .in_flit  (in_flit[p]),
      .in_full  (in_full[p]),
      .req      (req_bus[p])
    );

    // Head flits into the crossbar
    assign head_flit[p] = req_bus[p].flit;
  end

  // ----------------------------------------------------------
  // Allocation and switching
  // ----------------------------------------------------------
  mesh_switch_allocator u_alloc (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req_bus),
    .sel   (sel)
  );

  mesh_switch u_xbar (
    .sel      (sel),
    .in_data  (head_flit),
    .out_data (xbar_flit)
  );

  // ----------------------------------------------------------
  // Output registers
  // ----------------------------------------------------------
  // Any select bit means a flit crosses this cycle
  always_ff @(posedge clk) begin
    for (int o = 0; o < n_ports; o++) begin
      if (!rst_n) begin
        out_valid[o] <= 1'b0;
      end else begin
        out_valid[o] <= |sel[o];
      end
    end
  end

  // Flit data, qualified by out_valid
  always_ff @(posedge clk) begin
    for (int o = 0; o < n_ports; o++) begin
      out_flit[o] <= xbar_flit[o];
    end
  end

endmodule

/* mesh_switch.sv */
// ----------------------------------------------------------
// Mesh router crossbar
// 5x5 flit switch, each output picked by a one-hot select
// ----------------------------------------------------------

module mesh_switch import mesh_pkg::*; (
  input  logic [n_ports-1:0] sel      [0:n_ports-1],
  input  logic [flit_w-1:0]  in_data  [0:n_ports-1],
  output logic [flit_w-1:0]  out_data [0:n_ports-1]
);

  // ----------------------------------------------------------
  // One-hot mux per output
  // ----------------------------------------------------------
  // Bit n_ports-1-j selects input j
  // No select or a bad select gives a zero flit
  always_comb begin
    for (int o = 0; o < n_ports; o++) begin
      out_data[o] = '0;
      for (int j = 0; j < n_ports; j++) begin
        if (sel[o] == n_ports'(1 << (n_ports - 1 - j))) begin
          out_data[o] = in_data[j];
        end
      end
    end
  end

endmodule

/* mesh_switch_allocator.sv */
// ----------------------------------------------------------
// Mesh router switch allocator
// Round-robin arbiter per output, one-hot crossbar selects
// ----------------------------------------------------------

module mesh_switch_allocator import mesh_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  mesh_req_if.alloc          req [0:n_ports-1],
  output logic [n_ports-1:0] sel [0:n_ports-1]
);

  logic [n_ports-1:0]           valid_vec;
  logic [n_ports-1:0]           port_vec  [0:n_ports-1];
  logic [n_ports-1:0]           grant_vec;
  // Requests seen by each output, bit j is input j
  logic [n_ports-1:0]           out_req   [0:n_ports-1];
  logic [$clog2(n_ports)-1:0]   last_q    [0:n_ports-1];
  logic [$clog2(n_ports)-1:0]   win_idx   [0:n_ports-1];
  logic [n_ports-1:0]           win_valid;

  // ----------------------------------------------------------
  // Flatten the request buses
  // ----------------------------------------------------------
  for (genvar i = 0; i < n_ports; i++) begin : g_unpack
    assign valid_vec[i]  = req[i].valid;
    assign port_vec[i]   = req[i].req_port;
    assign req[i].grant  = grant_vec[i];
  end

  // Transpose input requests into per-output request masks
  always_comb begin
    for (int o = 0; o < n_ports; o++) begin
      for (int j = 0; j < n_ports; j++) begin
        out_req[o][j] = valid_vec[j] & port_vec[j][o];
      end
    end
  end

  // ----------------------------------------------------------
  // Round-robin search
  // ----------------------------------------------------------
  // Inputs above the last winner first, then wrap around
  always_comb begin
    grant_vec = '0;
    for (int o = 0; o < n_ports; o++) begin
      win_valid[o] = 1'b0;
      win_idx[o]   = '0;
      sel[o]       = '0;
      for (int j = 0; j < n_ports; j++) begin
        if (!win_valid[o] && j > last_q[o] && out_req[o][j]) begin
          win_valid[o] = 1'b1;
          win_idx[o]   = ($clog2(n_ports))'(j);
        end
      end
      for (int j = 0; j < n_ports; j++) begin
        if (!win_valid[o] && j <= last_q[o] && out_req[o][j]) begin
          win_valid[o] = 1'b1;
          win_idx[o]   = ($clog2(n_ports))'(j);
        end
      end
      // Reference bit order, bit n_ports-1-j picks input j
      if (win_valid[o]) begin
        sel[o][n_ports-1-win_idx[o]] = 1'b1;
        grant_vec[win_idx[o]]        = 1'b1;
      end
    end
  end

  // Last winner per output
  // Reset to the top index so input 0 goes first
  always_ff @(posedge clk) begin
    for (int o = 0; o < n_ports; o++) begin
      if (!rst_n) begin
        last_q[o] <= ($clog2(n_ports))'(n_ports - 1);
      end else if (win_valid[o]) begin
        last_q[o] <= win_idx[o];
      end
    end
  end

endmodule

/* mesh_input_unit.sv */
// ----------------------------------------------------------
// Mesh router input unit
// Flit FIFO with XY route computation on the head flit
// ----------------------------------------------------------

module mesh_input_unit import mesh_pkg::*; #(
  parameter int x_pos = 0,
  parameter int y_pos = 0
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  input  logic [flit_w-1:0] in_flit,
  output logic              in_full,
  mesh_req_if.unit          req
);

  // ----------------------------------------------------------
  // FIFO storage and pointers
  // ----------------------------------------------------------
  logic [flit_w-1:0]                  mem [0:fifo_depth-1];
  logic [$clog2(fifo_depth)-1:0]      wr_ptr;
  logic [$clog2(fifo_depth)-1:0]      rd_ptr;
  // Flits stored, drives in_full
  logic [$clog2(fifo_depth+1)-1:0]    count;
  // Flits visible at the head, trails count by one cycle
  logic [$clog2(fifo_depth+1)-1:0]    avail;
  logic                               push;
  logic                               push_q;
  logic                               pop;

  // Strobe while full is dropped
  assign push    = in_valid & ~in_full;
  assign pop     = req.grant;
  assign in_full = (count == fifo_depth);

  // Payload storage, no reset
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  // Control state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      avail  <= '0;
      push_q <= 1'b0;
    end else begin
      push_q <= push;
      if (push) begin
        wr_ptr <= (wr_ptr == fifo_depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == fifo_depth - 1) ? '0 : rd_ptr + 1'b1;
      end
      // Total occupancy
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Head visibility, written flit shows one cycle late
      case ({push_q, pop})
        2'b10:   avail <= avail + 1'b1;
        2'b01:   avail <= avail - 1'b1;
        default: avail <= avail;
      endcase
    end
  end

  // ----------------------------------------------------------
  // XY routing on the head flit
  // ----------------------------------------------------------
  logic [coord_w-1:0] dest_x;
  logic [coord_w-1:0] dest_y;

  assign req.valid = (avail != '0);
  assign req.flit  = mem[rd_ptr];
  assign dest_x    = req.flit[dest_x_lsb +: coord_w];
  assign dest_y    = req.flit[dest_y_lsb +: coord_w];

  // X first, larger X is east, larger Y is north
  always_comb begin
    req.req_port = '0;
    if (dest_x > coord_w'(x_pos)) begin
      req.req_port[port_east] = 1'b1;
    end else if (dest_x < coord_w'(x_pos)) begin
      req.req_port[port_west] = 1'b1;
    end else if (dest_y > coord_w'(y_pos)) begin
      req.req_port[port_north] = 1'b1;
    end else if (dest_y < coord_w'(y_pos)) begin
      req.req_port[port_south] = 1'b1;
    end else begin
      req.req_port[port_local] = 1'b1;
    end
  end

endmodule

/* mesh_req_if.sv */
// ----------------------------------------------------------
// Mesh router request bus
// Head flit, its requested output and the pop grant
// ----------------------------------------------------------

interface mesh_req_if import mesh_pkg::*; ();

  // Head flit present, held until grant
  logic               valid;
  // One-hot output request, bit o names output o
  logic [n_ports-1:0] req_port;
  // Head flit itself
  logic [flit_w-1:0]  flit;
  // Single-cycle pop pulse
  logic               grant;

  // Input unit side
  modport unit (output valid, output req_port, output flit, input grant);

  // Allocator and crossbar side
  modport alloc (input valid, input req_port, input flit, output grant);

endinterface

/* mesh_pkg.sv */
// ----------------------------------------------------------
// Mesh router shared definitions
// Flit field layout, port numbering, coordinate and FIFO sizes
// ----------------------------------------------------------

package mesh_pkg;

  // ----------------------------------------------------------
  // Ports
  // ----------------------------------------------------------
  localparam int n_ports    = 5;

  // Port indices, also the bit positions in req_port
  localparam int port_local = 0;
  localparam int port_north = 1;
  localparam int port_east  = 2;
  localparam int port_south = 3;
  localparam int port_west  = 4;

  // ----------------------------------------------------------
  // Flit layout
  // ----------------------------------------------------------
  // One mesh coordinate, up to 8x8 routers
  localparam int coord_w     = 3;
  localparam int payload_w   = 16;

  // Dest X in the top bits, then dest Y, then payload
  localparam int flit_w      = 2 * coord_w + payload_w;
  localparam int payload_lsb = 0;
  localparam int dest_y_lsb  = payload_lsb + payload_w;
  localparam int dest_x_lsb  = dest_y_lsb + coord_w;

  // ----------------------------------------------------------
  // Buffering
  // ----------------------------------------------------------
  // Flits held per input port
  localparam int fifo_depth  = 4;

endpackage
